//--- bench/exp_board_patterns.txt
# name op hold sw(hex) led_cmd(hex) blink spare_out spare_oe spare_in exp_sw exp_led
# ops: RST reset state, SPR random spares, LED mapping, SWH/PUL/STY switches, BLK blink
reset_state RST 1 000 000 0 0000 0000 0000 000 000
spare_random SPR 40 000 000 0 0000 0000 0000 000 000
led_1 LED 4 000 001 0 0000 0000 0000 000 001
led_2 LED 4 000 002 0 0000 0000 0000 000 002
led_3 LED 4 000 004 0 0000 0000 0000 000 004
led_4 LED 4 000 008 0 0000 0000 0000 000 008
led_5 LED 4 000 010 0 0000 0000 0000 000 010
led_6 LED 4 000 020 0 0000 0000 0000 000 020
led_7 LED 4 000 040 0 0000 0000 0000 000 040
led_8 LED 4 000 080 0 0000 0000 0000 000 080
tled_b LED 4 000 100 0 0000 0000 0000 000 100
tled_g LED 4 000 200 0 0000 0000 0000 000 200
tled_r LED 4 000 400 0 0000 0000 0000 000 400
led_all LED 4 000 7ff 0 0000 0000 0000 000 7ff
led_alt LED 4 000 555 0 0000 0000 0000 000 555
led_none LED 4 000 000 0 0000 0000 0000 000 000
sw_slide SWH 30 070 000 0 0000 0000 0000 070 000
sw_pulse PUL 3 00f 000 0 0000 0000 0000 070 000
sw_settle STY 30 070 000 0 0000 0000 0000 070 000
sw_bank SWH 30 00f 000 0 0000 0000 0000 00f 000
sw_board SWH 30 180 000 0 0000 0000 0000 180 000
sw_pulse2 PUL 2 1ff 000 0 0000 0000 0000 180 000
sw_settle2 STY 30 180 000 0 0000 0000 0000 180 000
sw_mix SWH 30 0a5 000 0 0000 0000 0000 0a5 000
sw_clear SWH 30 000 000 0 0000 0000 0000 000 000
blink BLK 100 000 3fe 1 0000 0000 0000 000 3fe
led_after LED 4 000 123 0 0000 0000 0000 000 123

//--- verilog.f
verilog/exp_pkg.sv
verilog/exp_tick_gen.sv
verilog/exp_sync.sv
verilog/exp_debounce.sv
verilog/exp_led_driver.sv
verilog/exp_pin_map.sv
verilog/exp_board.sv
bench/exp_board_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module exp_board -f verilog.f

sim:
	verilator --binary --timing --top-module exp_board_tb -f verilog.f -o exp_board_sim
	./obj_dir/exp_board_sim | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/exp_board_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exp_board_tb import exp_pkg::*; ();

	localparam int MAX_STEPS = 64;

	logic               clk;
	logic               reset;
	logic [PIN_W-1:0]   pin_in;
	logic               exp_present;
	logic               exp_spi_miso;
	led_state_t         led_cmd;
	logic               blink_en;
	logic [SPARE_W-1:0] spare_out;
	logic [SPARE_W-1:0] spare_oe;
	logic [PIN_W-1:0]   pin_out;
	logic [PIN_W-1:0]   pin_oe;
	sw_state_t          sw;
	logic [SPARE_W-1:0] spare_in;

	// One row of the pattern file per step
	reg [8*32-1:0]      t_name [MAX_STEPS];
	reg [8*3-1:0]       t_op [MAX_STEPS];
	int                 t_hold [MAX_STEPS];
	sw_state_t          t_sw [MAX_STEPS];
	led_state_t         t_led [MAX_STEPS];
	logic               t_blink [MAX_STEPS];
	logic [SPARE_W-1:0] t_so [MAX_STEPS];
	logic [SPARE_W-1:0] t_oe [MAX_STEPS];
	logic [SPARE_W-1:0] t_si [MAX_STEPS];
	sw_state_t          t_exp_sw [MAX_STEPS];
	led_state_t         t_exp_led [MAX_STEPS];

	int          n_steps;
	int          errors;
	int          cycles;
	int          cycle_limit;
	logic [31:0] lcg_state;

	exp_board #(.CLKS_PER_MS(4), .DEBOUNCE_TICKS(3), .BLINK_MS(5)) dut (
		.clk(clk), .reset(reset), .pin_in(pin_in), .exp_present(exp_present),
		.exp_spi_miso(exp_spi_miso), .led_cmd(led_cmd), .blink_en(blink_en),
		.spare_out(spare_out), .spare_oe(spare_oe), .pin_out(pin_out),
		.pin_oe(pin_oe), .sw(sw), .spare_in(spare_in)
	);

	always #50 clk = ~clk;

	// Run limit, armed once the patterns are loaded
	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout after %0d cycles, run did not complete", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// LED pins from the board's GPIO assignment
	function automatic logic [PIN_W-1:0] led_mask();
		logic [PIN_W-1:0] m;
		int               g [11];
		g = '{PIN_TLED_R, PIN_TLED_G, PIN_TLED_B, PIN_LED1, PIN_LED2, PIN_LED3,
			PIN_LED4, PIN_LED5, PIN_LED6, PIN_LED7, PIN_LED8};
		m = '0;
		foreach (g[i]) m[g[i]-2] = 1'b1;
		return m;
	endfunction

	function automatic led_state_t extract_leds(input logic [PIN_W-1:0] p);
		led_state_t r;
		r.tled = {p[PIN_TLED_R-2], p[PIN_TLED_G-2], p[PIN_TLED_B-2]};
		r.led = {p[PIN_LED8-2], p[PIN_LED7-2], p[PIN_LED6-2], p[PIN_LED5-2],
			p[PIN_LED4-2], p[PIN_LED3-2], p[PIN_LED2-2], p[PIN_LED1-2]};
		return r;
	endfunction

	// Switch fields and spare inputs placed on the connector
	function automatic logic [PIN_W-1:0] build_pins(input sw_state_t s,
		input logic [SPARE_W-1:0] si);
		logic [PIN_W-1:0] p;
		p = '0;
		p[SPARE_W-1:0] = si;
		p[PIN_SW8-2] = s.slide[2];
		p[PIN_SW7-2] = s.slide[1];
		p[PIN_SW6-2] = s.slide[0];
		p[PIN_SW1_1-2] = s.bank[3];
		p[PIN_SW1_2-2] = s.bank[2];
		p[PIN_SW1_3-2] = s.bank[1];
		p[PIN_SW1_4-2] = s.bank[0];
		return p;
	endfunction

	task automatic check_sw(input reg [8*32-1:0] name, input sw_state_t exp,
		input sw_state_t got);
		if (got !== exp) begin
			errors++;
			$display("FAILED %0s: sw expected %h, actual %h", name, exp, got);
		end
	endtask

	task automatic check_leds(input reg [8*32-1:0] name, input led_state_t exp,
		input led_state_t got);
		if (got !== exp) begin
			errors++;
			$display("FAILED %0s: leds expected %h, actual %h", name, exp, got);
		end
	endtask

	task automatic check_vec(input reg [8*32-1:0] name, input logic [PIN_W-1:0] exp,
		input logic [PIN_W-1:0] got);
		if (got !== exp) begin
			errors++;
			$display("FAILED %0s: vector expected %h, actual %h", name, exp, got);
		end
	endtask

	// Inputs change just after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic drive(input sw_state_t s, input led_state_t l, input logic b,
		input logic [SPARE_W-1:0] so, input logic [SPARE_W-1:0] oe,
		input logic [SPARE_W-1:0] si);
		pin_in = build_pins(s, si);
		exp_present = s.present;
		exp_spi_miso = s.spi_miso;
		led_cmd = l;
		blink_en = b;
		spare_out = so;
		spare_oe = oe;
	endtask

	task automatic load_patterns();
		int    fd;
		string line;
		n_steps = 0;
		fd = $fopen("bench/exp_board_patterns.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the pattern file");
		end else begin
			while ($fgets(line, fd) && n_steps < MAX_STEPS) begin
				// Skip comments and blank lines
				if (line.len() < 2 || line[0] == "#") continue;
				if ($sscanf(line, "%s %s %d %h %h %h %h %h %h %h %h",
					t_name[n_steps], t_op[n_steps], t_hold[n_steps], t_sw[n_steps],
					t_led[n_steps], t_blink[n_steps], t_so[n_steps], t_oe[n_steps],
					t_si[n_steps], t_exp_sw[n_steps], t_exp_led[n_steps]) == 11) begin
					n_steps++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_spare(input int k);
		logic [SPARE_W-1:0] so;
		logic [SPARE_W-1:0] oe;
		logic [SPARE_W-1:0] si;
		logic [SPARE_W-1:0] so_d1;
		logic [SPARE_W-1:0] oe_d1;
		logic [SPARE_W-1:0] si_d1;
		logic [SPARE_W-1:0] si_d2;
		so = t_so[k];
		oe = t_oe[k];
		si = t_si[k];
		so_d1 = '0;
		oe_d1 = '0;
		si_d1 = '0;
		for (int i = 0; i < t_hold[k] + 2; i++) begin
			step();
			// Outputs one cycle behind, inputs two
			if (i >= 1) begin
				check_vec(t_name[k], PIN_W'(so_d1), PIN_W'(pin_out[SPARE_W-1:0]));
				check_vec(t_name[k], led_mask() | PIN_W'(oe_d1), pin_oe);
			end
			if (i >= 2) check_vec(t_name[k], PIN_W'(si_d2), PIN_W'(spare_in));
			si_d2 = si_d1;
			if (i < t_hold[k]) begin
				so = SPARE_W'(lcg_next() >> 7);
				oe = SPARE_W'(lcg_next() >> 7);
				si = SPARE_W'(lcg_next() >> 7);
			end
			drive(t_sw[k], t_led[k], t_blink[k], so, oe, si);
			so_d1 = so;
			oe_d1 = oe;
			si_d1 = si;
		end
	endtask

	task automatic run_blink(input int k);
		int         toggles;
		logic       led1;
		logic       prev;
		led_state_t got;
		led_state_t exp;
		toggles = 0;
		prev = 1'b0;
		for (int i = 0; i < t_hold[k]; i++) begin
			step();
			led1 = pin_out[PIN_LED1-2];
			if (i >= 1 && led1 !== prev) toggles++;
			prev = led1;
			if (i >= 2) begin
				got = extract_leds(pin_out);
				exp = t_exp_led[k];
				// LED1 is counted separately
				exp.led[0] = got.led[0];
				check_leds(t_name[k], exp, got);
			end
			drive(t_sw[k], t_led[k], t_blink[k], t_so[k], t_oe[k], t_si[k]);
		end
		if (toggles < 4 || toggles > 5) begin
			errors++;
			$display("FAILED %0s: LED1 toggles expected 4 or 5, actual %0d",
				t_name[k], toggles);
		end
	endtask

	task automatic run_step(input int k);
		if (t_op[k] == "RST") begin
			// No clock edge since reset, registers hold their reset values
			check_vec(t_name[k], '0, pin_out);
			check_vec(t_name[k], led_mask(), pin_oe);
			check_sw(t_name[k], '0, sw);
			drive(t_sw[k], t_led[k], t_blink[k], t_so[k], t_oe[k], t_si[k]);
			step();
		end else if (t_op[k] == "SPR") begin
			run_spare(k);
		end else if (t_op[k] == "BLK") begin
			run_blink(k);
		end else if (t_op[k] == "LED") begin
			for (int i = 0; i < t_hold[k]; i++) begin
				step();
				// Previous pattern still on the pins one cycle in
				if (i == 1 && k > 0 && t_op[k-1] == "LED") begin
					check_leds(t_name[k], t_exp_led[k-1], extract_leds(pin_out));
				end
				if (i >= 2) check_leds(t_name[k], t_exp_led[k], extract_leds(pin_out));
				drive(t_sw[k], t_led[k], t_blink[k], t_so[k], t_oe[k], t_si[k]);
			end
		end else if (t_op[k] == "SWH") begin
			for (int i = 0; i < t_hold[k]; i++) begin
				step();
				drive(t_sw[k], t_led[k], t_blink[k], t_so[k], t_oe[k], t_si[k]);
			end
			step();
			check_sw(t_name[k], t_exp_sw[k], sw);
		end else if (t_op[k] == "PUL" || t_op[k] == "STY") begin
			// sw must not move during or after a short pulse
			for (int i = 0; i < t_hold[k]; i++) begin
				step();
				check_sw(t_name[k], t_exp_sw[k], sw);
				drive(t_sw[k], t_led[k], t_blink[k], t_so[k], t_oe[k], t_si[k]);
			end
		end else begin
			errors++;
			$display("%0s: unknown opcode in the pattern file", t_name[k]);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		errors = 0;
		cycles = 0;
		cycle_limit = 0;
		lcg_state = 32'h56b41ae8;
		// Busy inputs while in reset, the registers must clear anyway
		drive('1, '1, 1'b0, '1, '1, '1);
		load_patterns();
		cycle_limit = 200;
		for (int k = 0; k < n_steps; k++) cycle_limit += t_hold[k];
		if (n_steps == 0) begin
			errors++;
			$display("No test steps read from the pattern file");
		end
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int k = 0; k < n_steps; k++) run_step(k);
		$display("Errors: %0d in %0d steps", errors, n_steps);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/exp_board.sv
`timescale 1ns/1ps
`default_nettype none

module exp_board import exp_pkg::*; #(
	parameter int CLKS_PER_MS    = 50000,
	parameter int DEBOUNCE_TICKS = 8,
	parameter int BLINK_MS       = 500
) (
	input  logic               clk,
	input  logic               reset,
	input  logic [PIN_W-1:0]   pin_in,
	input  logic               exp_present,
	input  logic               exp_spi_miso,
	input  led_state_t         led_cmd,
	input  logic               blink_en,
	input  logic [SPARE_W-1:0] spare_out,
	input  logic [SPARE_W-1:0] spare_oe,
	output logic [PIN_W-1:0]   pin_out,
	output logic [PIN_W-1:0]   pin_oe,
	output sw_state_t          sw,
	output logic [SPARE_W-1:0] spare_in
);

	logic               tick;
	sw_state_t          sw_raw;
	sw_state_t          sw_sync;
	logic [SPARE_W-1:0] spare_raw;
	led_state_t         leds;

	// Shared millisecond time base
	exp_tick_gen #(.CLKS_PER_MS(CLKS_PER_MS)) u_tick (
		.clk(clk), .reset(reset), .tick(tick)
	);

	exp_pin_map u_pin_map (
		.clk(clk), .reset(reset),
		.pin_in(pin_in), .pin_out(pin_out), .pin_oe(pin_oe),
		.leds(leds), .spare_out(spare_out), .spare_oe(spare_oe),
		.exp_present(exp_present), .exp_spi_miso(exp_spi_miso),
		.sw_raw(sw_raw), .spare_raw(spare_raw)
	);

	// Switches and board pins into the clock domain
	exp_sync #(.payload_t(sw_state_t)) u_sync_sw (
		.clk(clk), .reset(reset), .d(sw_raw), .q(sw_sync)
	);

	// Spare pins go out synchronized only
	exp_sync #(.payload_t(logic [SPARE_W-1:0])) u_sync_spare (
		.clk(clk), .reset(reset), .d(spare_raw), .q(spare_in)
	);

	exp_debounce #(.DEBOUNCE_TICKS(DEBOUNCE_TICKS)) u_debounce (
		.clk(clk), .reset(reset), .tick(tick), .raw(sw_sync), .sw(sw)
	);

	exp_led_driver #(.BLINK_MS(BLINK_MS)) u_led (
		.clk(clk), .reset(reset), .tick(tick), .blink_en(blink_en),
		.led_cmd(led_cmd), .leds(leds)
	);

endmodule

`default_nettype wire

//--- verilog/exp_pin_map.sv
`timescale 1ns/1ps
`default_nettype none

module exp_pin_map import exp_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic [PIN_W-1:0]   pin_in,
	output logic [PIN_W-1:0]   pin_out,
	output logic [PIN_W-1:0]   pin_oe,
	input  led_state_t         leds,
	input  logic [SPARE_W-1:0] spare_out,
	input  logic [SPARE_W-1:0] spare_oe,
	input  logic               exp_present,
	input  logic               exp_spi_miso,
	output sw_state_t          sw_raw,
	output logic [SPARE_W-1:0] spare_raw
);

	// LED pins are always outputs
	localparam logic [PIN_W-1:0] LED_MASK = PIN_W'(
		(1 << (PIN_TLED_R - 2)) | (1 << (PIN_TLED_G - 2)) | (1 << (PIN_TLED_B - 2)) |
		(1 << (PIN_LED1 - 2)) | (1 << (PIN_LED2 - 2)) | (1 << (PIN_LED3 - 2)) |
		(1 << (PIN_LED4 - 2)) | (1 << (PIN_LED5 - 2)) | (1 << (PIN_LED6 - 2)) |
		(1 << (PIN_LED7 - 2)) | (1 << (PIN_LED8 - 2)));

	logic [PIN_W-1:0] out_next;
	logic [PIN_W-1:0] oe_next;

	// Switch fields straight off the connector
	assign sw_raw.present  = exp_present;
	assign sw_raw.spi_miso = exp_spi_miso;
	assign sw_raw.slide    = {pin_in[PIN_SW8-2], pin_in[PIN_SW7-2], pin_in[PIN_SW6-2]};
	assign sw_raw.bank     = {pin_in[PIN_SW1_1-2], pin_in[PIN_SW1_2-2],
		pin_in[PIN_SW1_3-2], pin_in[PIN_SW1_4-2]};
	// Spares sit at the bottom of the vector
	assign spare_raw = pin_in[SPARE_W-1:0];

	always_comb begin
		// Unused and switch pins stay low
		out_next = '0;
		out_next[SPARE_W-1:0] = spare_out;
		out_next[PIN_TLED_R-2] = leds.tled[2];
		out_next[PIN_TLED_G-2] = leds.tled[1];
		out_next[PIN_TLED_B-2] = leds.tled[0];
		out_next[PIN_LED1-2] = leds.led[0];
		out_next[PIN_LED2-2] = leds.led[1];
		out_next[PIN_LED3-2] = leds.led[2];
		out_next[PIN_LED4-2] = leds.led[3];
		out_next[PIN_LED5-2] = leds.led[4];
		out_next[PIN_LED6-2] = leds.led[5];
		out_next[PIN_LED7-2] = leds.led[6];
		out_next[PIN_LED8-2] = leds.led[7];
		// Spare direction set by the host
		oe_next = LED_MASK | {{(PIN_W - SPARE_W){1'b0}}, spare_oe};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pin_out <= '0;
			pin_oe  <= LED_MASK;
		end else begin
			pin_out <= out_next;
			pin_oe  <= oe_next;
		end
	end

endmodule

`default_nettype wire

//--- verilog/exp_led_driver.sv
`timescale 1ns/1ps
`default_nettype none

module exp_led_driver import exp_pkg::*; #(
	parameter int BLINK_MS = 500
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       tick,
	input  logic       blink_en,
	input  led_state_t led_cmd,
	output led_state_t leds
);

	// Millisecond counter for the half period
	localparam int CNT_W = (BLINK_MS > 1) ? $clog2(BLINK_MS) : 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(BLINK_MS - 1);

	logic [CNT_W-1:0] ms_cnt;
	logic             phase;
	led_state_t       leds_next;

	always_ff @(posedge clk) begin
		if (reset) begin
			ms_cnt <= '0;
			phase  <= 1'b0;
		end else if (!blink_en) begin
			// Blink off, hold at phase zero
			ms_cnt <= '0;
			phase  <= 1'b0;
		end else if (tick) begin
			if (ms_cnt == LAST) begin
				ms_cnt <= '0;
				phase  <= ~phase;
			end else begin
				ms_cnt <= ms_cnt + 1'b1;
			end
		end
	end

	// LED1 comes from the phase while blinking
	always_comb begin
		leds_next = led_cmd;
		if (blink_en) begin
			leds_next.led[0] = phase;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			leds <= '0;
		end else begin
			leds <= leds_next;
		end
	end

endmodule

`default_nettype wire

//--- verilog/exp_debounce.sv
`timescale 1ns/1ps
`default_nettype none

module exp_debounce import exp_pkg::*; #(
	parameter int DEBOUNCE_TICKS = 8
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      tick,
	input  sw_state_t raw,
	output sw_state_t sw
);

	localparam int SW_W = $bits(sw_state_t);
	// Counter holds 0 to DEBOUNCE_TICKS-1
	localparam int CNT_W = (DEBOUNCE_TICKS > 1) ? $clog2(DEBOUNCE_TICKS) : 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(DEBOUNCE_TICKS - 1);

	logic [SW_W-1:0] raw_bits;
	logic [SW_W-1:0] sw_bits;
	logic [CNT_W-1:0] cnt [SW_W];

	// Flat views of the struct
	assign raw_bits = raw;
	assign sw = sw_bits;

	always_ff @(posedge clk) begin
		if (reset) begin
			sw_bits <= '0;
			for (int i = 0; i < SW_W; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < SW_W; i++) begin
				if (raw_bits[i] == sw_bits[i]) begin
					// Input agrees with state, restart
					cnt[i] <= '0;
				end else if (tick) begin
					if (cnt[i] == LAST) begin
						// Stable long enough, accept
						sw_bits[i] <= raw_bits[i];
						cnt[i]     <= '0;
					end else begin
						cnt[i] <= cnt[i] + 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/exp_sync.sv
`timescale 1ns/1ps
`default_nettype none

module exp_sync #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  payload_t d,
	output payload_t q
);

	// First stage, may go metastable
	payload_t meta;

	always_ff @(posedge clk) begin
		if (reset) begin
			meta <= '0;
			q    <= '0;
		end else begin
			meta <= d;
			// Second stage settles before use
			q    <= meta;
		end
	end

endmodule

`default_nettype wire

//--- verilog/exp_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module exp_tick_gen #(
	parameter int CLKS_PER_MS = 50000
) (
	input  logic clk,
	input  logic reset,
	output logic tick
);

	// Counter wide enough for CLKS_PER_MS-1, at least one bit
	localparam int CNT_W = (CLKS_PER_MS > 1) ? $clog2(CLKS_PER_MS) : 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_MS - 1);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt  <= '0;
			tick <= 1'b0;
		end else begin
			tick <= 1'b0;
			if (cnt == LAST) begin
				// Wrap, one pulse per period
				cnt  <= '0;
				tick <= 1'b1;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/exp_pkg.sv
`default_nettype none

package exp_pkg;

	// Connector GPIO 2 to 32, vector index 0 is GPIO 2
	localparam int PIN_W = 31;
	// Spare pins GPIO 2 to 14
	localparam int SPARE_W = 13;

	// Switch pins, as GPIO numbers
	localparam int PIN_SW8 = 17;
	localparam int PIN_SW7 = 18;
	localparam int PIN_SW6 = 19;
	localparam int PIN_SW1_1 = 27;
	localparam int PIN_SW1_2 = 26;
	localparam int PIN_SW1_3 = 16;
	localparam int PIN_SW1_4 = 15;

	// RGB T LED
	localparam int PIN_TLED_B = 20;
	localparam int PIN_TLED_G = 21;
	localparam int PIN_TLED_R = 22;

	// Single LEDs
	localparam int PIN_LED1 = 24;
	localparam int PIN_LED2 = 32;
	localparam int PIN_LED3 = 30;
	localparam int PIN_LED4 = 28;
	localparam int PIN_LED5 = 23;
	localparam int PIN_LED6 = 25;
	localparam int PIN_LED7 = 31;
	localparam int PIN_LED8 = 29;

	typedef struct packed {
		logic       present;
		logic       spi_miso;
		logic [2:0] slide; // SW8, SW7, SW6
		logic [3:0] bank;  // SW1_1 to SW1_4
	} sw_state_t;

	typedef struct packed {
		logic [2:0] tled; // R, G, B
		logic [7:0] led;  // LED8 down to LED1
	} led_state_t;

endpackage

`default_nettype wire
